// ==== bench/frontend_tb.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module frontend_tb;

  localparam int RESET_CYCLES   = 8;
  localparam int RUN_CYCLES     = 500;
  localparam int TIMEOUT_CYCLES = 6 * RUN_CYCLES;
  localparam int DRIVE_DELAY    = 2;
  localparam int REDIRECTS      = 3;

  // redirect points and targets with word offsets 0, 1 and 3
  localparam int          REDIR_CYC0 = 120;
  localparam int          REDIR_CYC1 = 250;
  localparam int          REDIR_CYC2 = 380;
  localparam logic [31:0] TARGET0    = 32'h0000_0100;
  localparam logic [31:0] TARGET1    = 32'h0000_0234;
  localparam logic [31:0] TARGET2    = 32'h0000_037c;

  logic                        clk;
  logic                        rst;
  logic                        redirect;
  logic [31:0]                 redirect_pc;
  logic                        issue_ready;
  logic                        imem_req;
  logic [31:0]                 imem_addr;
  logic                        imem_resp_valid;
  logic [127:0]                imem_resp_data;
  frontend_pkg::issue_slot_t   issue0;
  frontend_pkg::issue_slot_t   issue1;

  integer      seed;
  int          errors;
  int          issued;
  int          dual_cycles;
  int          targets_hit;
  int unsigned cycle_count;
  logic        rst_q;
  logic [31:0] exp_pc;         // next pc in program order
  logic [31:0] target_pc;
  logic        await_target;   // target of the last redirect not yet issued
  logic        await_fetch;    // first request for the target not yet seen

  frontend_top DUT (
    .clk             (clk),
    .rst             (rst),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .issue_ready     (issue_ready),
    .imem_req        (imem_req),
    .imem_addr       (imem_addr),
    .imem_resp_valid (imem_resp_valid),
    .imem_resp_data  (imem_resp_data),
    .issue0          (issue0),
    .issue1          (issue1)
  );

  imem_model u_imem (
    .clk        (clk),
    .rst        (rst),
    .req        (imem_req),
    .addr       (imem_addr),
    .resp_valid (imem_resp_valid),
    .resp_data  (imem_resp_data)
  );

  // ****************************************
  // helpers
  // ****************************************
  function automatic logic [31:0] imem_word(input logic [31:0] pc);
    return u_imem.mem[pc[9:2]];
  endfunction

  // start of the fetch block holding this pc
  function automatic logic [31:0] block_base(input logic [31:0] pc);
    return pc & ~32'(4 * `FE_BLOCK_WORDS - 1);
  endfunction

  function automatic logic is_control_flow(input logic [31:0] instr);
    return (instr[6:0] == 7'b1100011) || (instr[6:0] == 7'b1101111) ||
           (instr[6:0] == 7'b1100111);
  endfunction

  // second word reads the first one's destination
  function automatic logic reads_result(input logic [31:0] first, input logic [31:0] second);
    return (first[11:7] != 5'd0) &&
           ((first[11:7] == second[19:15]) || (first[11:7] == second[24:20]));
  endfunction

  task automatic count_mismatch(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
    errors++;
    $display("Fail %s: expected %h, actual %h", test, expected, actual);
  endtask

  task automatic count_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  // ****************************************
  // clock and timeout
  // ****************************************
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, stimulus never completed", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // ****************************************
  // scoreboard state
  // ****************************************
  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      exp_pc       <= `FE_RESET_PC;
      target_pc    <= `FE_RESET_PC;
      await_target <= 1'b0;
      await_fetch  <= 1'b1;
    end else begin
      issued <= issued + int'(issue0.valid) + int'(issue1.valid);
      if (issue0.valid && issue1.valid) begin
        dual_cycles <= dual_cycles + 1;
      end
      if (redirect) begin
        exp_pc       <= redirect_pc;
        target_pc    <= redirect_pc;
        await_target <= 1'b1;
        await_fetch  <= 1'b1;
      end else begin
        exp_pc <= exp_pc + (issue0.valid ? 32'd4 : 32'd0) + (issue1.valid ? 32'd4 : 32'd0);
        if (await_target && issue0.valid) begin
          await_target <= 1'b0;
          targets_hit  <= targets_hit + 1;
        end
        if (imem_req) begin
          await_fetch <= 1'b0;
        end
      end
    end
  end

  // ****************************************
  // checks
  // ****************************************
  assert property (@(posedge clk) rst_q |-> !imem_req && !issue0.valid && !issue1.valid)
    else count_failure("outputs active during reset or the cycle after it");

  // fetch restarts at the block of the reset pc or the redirect target
  assert property (@(posedge clk) disable iff (rst)
    await_fetch && imem_req |-> imem_addr == block_base(target_pc))
    else count_mismatch("first fetch address", block_base($sampled(target_pc)),
                        $sampled(imem_addr));

  assert property (@(posedge clk) disable iff (rst) issue0.valid |-> issue0.pc == exp_pc)
    else count_mismatch("issue0 pc", $sampled(exp_pc), $sampled(issue0.pc));

  assert property (@(posedge clk) disable iff (rst)
    issue1.valid |-> issue1.pc == exp_pc + 32'd4)
    else count_mismatch("issue1 pc", $sampled(exp_pc) + 32'd4, $sampled(issue1.pc));

  assert property (@(posedge clk) disable iff (rst)
    issue0.valid |-> issue0.instr == imem_word(issue0.pc))
    else count_mismatch("issue0 instr", imem_word($sampled(issue0.pc)),
                        $sampled(issue0.instr));

  assert property (@(posedge clk) disable iff (rst)
    issue1.valid |-> issue1.instr == imem_word(issue1.pc))
    else count_mismatch("issue1 instr", imem_word($sampled(issue1.pc)),
                        $sampled(issue1.instr));

  assert property (@(posedge clk) disable iff (rst)
    issue1.valid |-> !is_control_flow(issue0.instr))
    else count_failure("second slot issued behind a control-flow instruction");

  assert property (@(posedge clk) disable iff (rst)
    issue1.valid |-> !reads_result(issue0.instr, issue1.instr))
    else count_failure("second slot issued while reading the first slot's rd");

  assert property (@(posedge clk) disable iff (rst)
    !issue_ready |-> !issue0.valid && !issue1.valid)
    else count_failure("instruction issued while issue_ready was low");

  assert property (@(posedge clk) disable iff (rst)
    await_target && issue0.valid |-> issue0.pc == target_pc)
    else count_mismatch("redirect target", $sampled(target_pc), $sampled(issue0.pc));

  // ****************************************
  // stimulus
  // ****************************************
  initial begin
    seed         = 32'hc6968514;
    errors       = 0;
    issued       = 0;
    dual_cycles  = 0;
    targets_hit  = 0;
    rst_q        = 1'b0;
    rst          = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = '0;
    issue_ready  = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      issue_ready = (($random(seed) & 3) != 0);   // about 75% high
      redirect    = 1'b0;
      case (cyc)
        REDIR_CYC0: begin
          redirect    = 1'b1;
          redirect_pc = TARGET0;
        end
        REDIR_CYC1: begin
          redirect    = 1'b1;
          redirect_pc = TARGET1;
        end
        REDIR_CYC2: begin
          redirect    = 1'b1;
          redirect_pc = TARGET2;
        end
        default: ;
      endcase
      @(posedge clk);
      #DRIVE_DELAY;
    end

    if (dual_cycles == 0) begin
      count_failure("no cycle with both issue slots valid");
    end
    if (targets_hit != REDIRECTS) begin
      count_failure("not every redirect target was issued");
    end

    $display("errors %0d, issued %0d, dual-issue cycles %0d, redirect targets issued %0d",
             errors, issued, dual_cycles, targets_hit);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== bench/imem_model.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module imem_model (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req,
  input  logic [31:0]                    addr,
  output logic                           resp_valid,
  output logic [32*`FE_BLOCK_WORDS-1:0]  resp_data
);

  localparam int         MEM_WORDS = 256;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] word;
  integer      seed;
  logic [5:0]  blk;

  assign blk = addr[9:4];   // 64 blocks of 4 words, wraps

  // random program, every fifth word a branch
  initial begin
    seed = 32'hc6968514;
    for (int i = 0; i < MEM_WORDS; i++) begin
      word = $random(seed);
      if (i % 5 == 0) begin
        word[6:0] = OP_BRANCH;
      end
      mem[i] = word;
    end
  end

  // answer every request on the next cycle, word 0 lowest
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_data  <= '0;
    end else begin
      resp_valid <= req;
      if (req) begin
        for (int i = 0; i < `FE_BLOCK_WORDS; i++) begin
          resp_data[32*i +: 32] <= mem[{blk, 2'(i)}];
        end
      end
    end
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/frontend_pkg.sv
rtl/fetch_unit.sv
rtl/instr_buffer.sv
rtl/issue_select.sv
rtl/frontend_top.sv
bench/imem_model.sv
bench/frontend_tb.sv

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           redirect,
  input  logic [31:0]                    redirect_pc,
  input  logic [`FE_IB_DEPTH_LOG2:0]     fill,
  output logic                           imem_req,
  output logic [31:0]                    imem_addr,
  input  logic                           imem_resp_valid,
  input  logic [32*`FE_BLOCK_WORDS-1:0]  imem_resp_data,
  output frontend_pkg::fetch_packet_t    push_pkt
);

  localparam int OFS_W   = $clog2(`FE_BLOCK_WORDS);
  localparam int BLK_LSB = OFS_W + 2;
  localparam logic [31:0] BLK_BYTES = 32'(4 * `FE_BLOCK_WORDS);
  // room for a whole block, pops can only add to it
  localparam logic [`FE_IB_DEPTH_LOG2:0] FILL_MAX =
    (`FE_IB_DEPTH_LOG2 + 1)'(`FE_IB_DEPTH - `FE_BLOCK_WORDS);

  logic [31:0]      pc;
  logic             pending;    // request out, answer due this cycle
  logic             started;    // first cycle out of reset is idle
  logic             resp_take;
  logic [OFS_W-1:0] offset;
  logic [31:0]      blk_addr;

  assign offset    = pc[BLK_LSB-1:2];
  assign blk_addr  = {pc[31:BLK_LSB], {BLK_LSB{1'b0}}};
  assign imem_addr = blk_addr;

  assign imem_req  = started && !pending && !redirect && (fill <= FILL_MAX);

  // answer to a request made before a redirect is dropped
  assign resp_take = imem_resp_valid && pending && !redirect;

  // ****************************************
  // pc and request state
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= `FE_RESET_PC;
      pending <= 1'b0;
      started <= 1'b0;
    end else begin
      started <= 1'b1;
      if (redirect) begin
        pc      <= redirect_pc;
        pending <= 1'b0;
      end else if (resp_take) begin
        pc      <= blk_addr + BLK_BYTES;   // next block boundary
        pending <= 1'b0;
      end else if (imem_req) begin
        pending <= 1'b1;
      end
    end
  end

  // ****************************************
  // response alignment
  // ****************************************
  // words from the pc offset onward slide down to lane 0
  always_comb begin
    push_pkt = '0;
    for (int i = 0; i < `FE_BLOCK_WORDS; i++) begin
      if (i + offset < `FE_BLOCK_WORDS) begin
        push_pkt.lane[i].valid     = resp_take;
        push_pkt.lane[i].pc        = pc + 32'(4 * i);
        push_pkt.lane[i].instr.raw = imem_resp_data[32*(i + offset) +: 32];
      end
    end
    if (resp_take) begin
      push_pkt.count = 3'(`FE_BLOCK_WORDS) - 3'(offset);
    end
  end

  // one request at a time, memory answers on the very next cycle
  assert property (@(posedge clk) disable iff (rst)
    imem_req |=> !imem_req && imem_resp_valid)
    else $error("fetch_unit: request not answered one cycle later");

endmodule

// ==== rtl/frontend_defines.svh ====
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// ****************************************
// instruction buffer geometry
// ****************************************
`define FE_IB_DEPTH       16
`define FE_IB_DEPTH_LOG2  4      // fill level is one bit wider

// ****************************************
// fetch
// ****************************************
`define FE_RESET_PC       32'h0000_0000
`define FE_BLOCK_WORDS    4      // words per imem block

// opcodes that end a dual-issue pair
`define FE_OP_BRANCH      7'b1100011
`define FE_OP_JAL         7'b1101111
`define FE_OP_JALR        7'b1100111

`endif

// ==== rtl/frontend_pkg.sv ====
`include "frontend_defines.svh"

package frontend_pkg;

  // standard R-type layout, only the hazard fields matter here
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fields_t;

  // same word, seen raw or split into fields
  typedef union packed {
    logic [31:0]   raw;
    instr_fields_t fields;
  } instr_word_u;

  // one buffer slot, valid on top
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_word_u instr;
  } ib_entry_t;

  // fetch to buffer, lane 0 is the oldest
  typedef struct packed {
    ib_entry_t [`FE_BLOCK_WORDS-1:0] lane;
    logic [2:0]                      count;   // 0..4 lanes to push
  } fetch_packet_t;

  // one issue port
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } issue_slot_t;

endpackage

// ==== rtl/frontend_top.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module frontend_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           redirect,
  input  logic [31:0]                    redirect_pc,
  input  logic                           issue_ready,
  output logic                           imem_req,
  output logic [31:0]                    imem_addr,
  input  logic                           imem_resp_valid,
  input  logic [32*`FE_BLOCK_WORDS-1:0]  imem_resp_data,
  output frontend_pkg::issue_slot_t      issue0,
  output frontend_pkg::issue_slot_t      issue1
);

  frontend_pkg::fetch_packet_t      push_pkt;
  frontend_pkg::ib_entry_t          head0;
  frontend_pkg::ib_entry_t          head1;
  logic [`FE_IB_DEPTH_LOG2:0]       fill;
  logic [1:0]                       pop_op;

  fetch_unit u_fetch (
    .clk             (clk),
    .rst             (rst),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .fill            (fill),
    .imem_req        (imem_req),
    .imem_addr       (imem_addr),
    .imem_resp_valid (imem_resp_valid),
    .imem_resp_data  (imem_resp_data),
    .push_pkt        (push_pkt)
  );

  instr_buffer u_ibuf (
    .clk      (clk),
    .rst      (rst),
    .flush    (redirect),     // redirect empties the queue
    .push_pkt (push_pkt),
    .pop_op   (pop_op),
    .fill     (fill),
    .head0    (head0),
    .head1    (head1)
  );

  issue_select u_issue (
    .head0       (head0),
    .head1       (head1),
    .issue_ready (issue_ready),
    .pop_op      (pop_op),
    .issue0      (issue0),
    .issue1      (issue1)
  );

  // ****************************************
  // cross-block checks
  // ****************************************
  // slot 1 only together with slot 0 and on the next word
  assert property (@(posedge clk) disable iff (rst)
    issue1.valid |-> issue0.valid && (issue1.pc == issue0.pc + 32'd4))
    else $error("frontend_top: bad pair, pc0 %h pc1 %h", issue0.pc, issue1.pc);

endmodule

// ==== rtl/instr_buffer.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module instr_buffer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush,
  input  frontend_pkg::fetch_packet_t  push_pkt,
  input  logic [1:0]                   pop_op,
  output logic [`FE_IB_DEPTH_LOG2:0]   fill,
  output frontend_pkg::ib_entry_t      head0,
  output frontend_pkg::ib_entry_t      head1
);

  localparam int PW = `FE_IB_DEPTH_LOG2;

  frontend_pkg::ib_entry_t mem [`FE_IB_DEPTH];

  logic [PW-1:0] head_ptr;
  logic [PW-1:0] tail_ptr;
  logic [PW:0]   count;
  logic [1:0]    pop_num;

  // pop code: 00 none, 01 one, 11 two
  // 10 is never produced by issue_select and counts as none
  always_comb begin
    case (pop_op)
      2'b01:   pop_num = 2'd1;
      2'b11:   pop_num = 2'd2;
      default: pop_num = 2'd0;
    endcase
  end

  // ****************************************
  // pointers and fill level
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      tail_ptr <= tail_ptr + PW'(push_pkt.count);   // wraps
      head_ptr <= head_ptr + PW'(pop_num);
      count    <= count + (PW+1)'(push_pkt.count) - (PW+1)'(pop_num);
    end
  end

  assign fill = count;

  // ****************************************
  // storage
  // ****************************************
  // up to four consecutive slots from the tail
  always_ff @(posedge clk) begin
    for (int i = 0; i < `FE_BLOCK_WORDS; i++) begin
      if (i < push_pkt.count) begin
        mem[tail_ptr + PW'(i)] <= push_pkt.lane[i];
      end
    end
  end

  // head valids come from the fill level, stale slots never show
  always_comb begin
    head0       = mem[head_ptr];
    head0.valid = mem[head_ptr].valid && (count != '0);
    head1       = mem[head_ptr + PW'(1)];
    head1.valid = mem[head_ptr + PW'(1)].valid && (count >= (PW+1)'(2));
  end

  // fetch only asks when a full block still fits
  assert property (@(posedge clk) disable iff (rst || flush)
    (PW+2)'(count) + (PW+2)'(push_pkt.count) <= (PW+2)'(`FE_IB_DEPTH))
    else $error("instr_buffer: push overflows, fill %0d count %0d",
                count, push_pkt.count);

  // issue side never takes more than it can see
  assert property (@(posedge clk) disable iff (rst || flush)
    (PW+1)'(pop_num) <= count)
    else $error("instr_buffer: pop %0d with fill %0d", pop_num, count);

endmodule

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module issue_select (
  input  frontend_pkg::ib_entry_t    head0,
  input  frontend_pkg::ib_entry_t    head1,
  input  logic                       issue_ready,
  output logic [1:0]                 pop_op,
  output frontend_pkg::issue_slot_t  issue0,
  output frontend_pkg::issue_slot_t  issue1
);

  logic [6:0] op0;
  logic [4:0] rd0;
  logic [4:0] rs1_1;
  logic [4:0] rs2_1;
  logic       ctrl0;      // head0 redirects flow
  logic       raw_dep;    // head1 reads head0's result

  assign op0   = head0.instr.fields.opcode;
  assign rd0   = head0.instr.fields.rd;
  assign rs1_1 = head1.instr.fields.rs1;
  assign rs2_1 = head1.instr.fields.rs2;

  assign ctrl0 = (op0 == `FE_OP_BRANCH) || (op0 == `FE_OP_JAL) || (op0 == `FE_OP_JALR);

  // x0 never creates a dependency
  // rs fields of non R-type formats are compared too, only costs a slot
  assign raw_dep = (rd0 != 5'd0) && ((rd0 == rs1_1) || (rd0 == rs2_1));

  // ****************************************
  // slot decision
  // ****************************************
  always_comb begin
    issue0.valid = head0.valid && issue_ready;
    issue0.pc    = head0.pc;
    issue0.instr = head0.instr.raw;

    issue1.valid = issue0.valid && head1.valid && !ctrl0 && !raw_dep;
    issue1.pc    = head1.pc;
    issue1.instr = head1.instr.raw;
  end

  // pop code follows the number issued: 00 none, 01 one, 11 two
  // 10 cannot occur since slot 1 needs slot 0
  assign pop_op = {issue1.valid, issue0.valid};

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
  -f filelist.f -o frontend_sim || exit 1

out=$(./obj_dir/frontend_sim)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && exit 0 || exit 1
